// ==== src/dlx_pkg.sv ====
package dlx_pkg;

    //////////////////////////////
    // basic types
    //////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // primary opcodes, dlx encoding
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beqz  = 6'h04,
        op_bnez  = 6'h05,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // r-type function field
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_slt = 6'h2a
    } func_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // add r0,r0,r0
    localparam word_t NOP_INSTR = 32'h0000_0020;

    //////////////////////////////
    // instruction fields
    //////////////////////////////

    localparam int OPC_LSB  = 26;
    localparam int RS1_LSB  = 21;
    localparam int RS2_LSB  = 16;
    localparam int RD_LSB   = 11;
    localparam int FUNC_LSB = 0;
    localparam int IMM_LSB  = 0;
    localparam int IMM_W    = 16;
    localparam int OFF_LSB  = 0;
    localparam int OFF_W    = 26;

endpackage

// ==== src/dlx_fetch.sv ====
`timescale 1ns/1ns

module dlx_fetch #(
    parameter dlx_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           redirect,
    input  dlx_pkg::word_t redirect_pc,
    input  logic           load_stall,
    input  logic           mem_hold,
    output logic           fetch_req,
    output dlx_pkg::word_t fetch_addr,
    input  logic           fetch_done,
    input  dlx_pkg::word_t fetch_rdata,
    output dlx_pkg::word_t id_instr,
    output dlx_pkg::word_t id_next_pc
);
    import dlx_pkg::*;

    word_t pc;
    word_t pc_plus4;
    word_t pend_pc;
    logic  pend;
    logic  fetch_en;
    logic  steer;
    word_t steer_pc;

    // bus stays idle for one cycle after reset
    assign fetch_req  = fetch_en;
    assign fetch_addr = pc;
    assign pc_plus4   = pc + 32'd4;

    // a redirect during a stalled fetch waits for the handshake
    assign steer    = redirect | pend;
    assign steer_pc = redirect ? redirect_pc : pend_pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            fetch_en <= 1'b0;
            pend     <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (!mem_hold) begin
                if (steer && fetch_done) begin
                    pc   <= steer_pc;
                    pend <= 1'b0;
                end else if (steer) begin
                    pend <= 1'b1;
                end else if (fetch_done && !load_stall) begin
                    pc <= pc_plus4;
                end
            end
        end
    end

    // target kept while the old fetch drains
    always_ff @(posedge clk) begin
        if (redirect) begin
            pend_pc <= redirect_pc;
        end
    end

    //////////////////////////////
    // IF/ID register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            id_instr <= NOP_INSTR;
        end else if (!mem_hold && (steer || !load_stall)) begin
            // squashed or missing fetch becomes a bubble
            id_instr <= (fetch_done && !steer) ? fetch_rdata : NOP_INSTR;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_hold && !load_stall) begin
            id_next_pc <= pc_plus4;
        end
    end

endmodule

// ==== src/dlx_regfile.sv ====
`timescale 1ns/1ns

module dlx_regfile (
    input  logic              clk,
    input  logic              rst,
    input  dlx_pkg::reg_idx_t rs1,
    input  dlx_pkg::reg_idx_t rs2,
    output dlx_pkg::word_t    rs1_val,
    output dlx_pkg::word_t    rs2_val,
    input  logic              wb_we,
    input  dlx_pkg::reg_idx_t wb_rd,
    input  dlx_pkg::word_t    wb_val
);
    import dlx_pkg::*;

    word_t regs [32];

    // r0 reads zero
    // a same-cycle write passes through
    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_we && wb_rd == idx) begin
            return wb_val;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1);
        rs2_val = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_val;
        end
    end

endmodule

// ==== src/dlx_decode.sv ====
`timescale 1ns/1ns

module dlx_decode (
    input  logic              clk,
    input  logic              rst,
    input  dlx_pkg::word_t    id_instr,
    input  dlx_pkg::word_t    id_next_pc,
    output dlx_pkg::reg_idx_t rs1,
    output dlx_pkg::reg_idx_t rs2,
    input  dlx_pkg::word_t    rs1_val,
    input  dlx_pkg::word_t    rs2_val,
    input  logic              load_stall,
    input  logic              mem_hold,
    input  logic              redirect,
    output dlx_pkg::word_t    ex_next_pc,
    output dlx_pkg::word_t    ex_a,
    output dlx_pkg::word_t    ex_b,
    output dlx_pkg::word_t    ex_imm,
    output dlx_pkg::reg_idx_t ex_rs1,
    output dlx_pkg::reg_idx_t ex_rs2,
    output dlx_pkg::reg_idx_t ex_rd,
    output dlx_pkg::alu_op_t  ex_alu_op,
    output logic              ex_use_imm,
    output logic              ex_reg_write,
    output logic              ex_load,
    output logic              ex_store,
    output logic              ex_branch,
    output logic              ex_branch_nz,
    output logic              ex_jump
);
    import dlx_pkg::*;

    opcode_t  opcode;
    func_t    func;
    alu_op_t  alu_op;
    word_t    imm;
    reg_idx_t rd;
    logic     use_imm;
    logic     reg_write;
    logic     load;
    logic     store;
    logic     branch;
    logic     branch_nz;
    logic     jump;

    assign opcode = opcode_t'(id_instr[OPC_LSB +: 6]);
    assign func   = func_t'(id_instr[FUNC_LSB +: 6]);
    assign rs1    = id_instr[RS1_LSB +: 5];
    assign rs2    = id_instr[RS2_LSB +: 5];

    always_comb begin
        alu_op    = alu_add;
        use_imm   = 1'b1;
        reg_write = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        branch    = 1'b0;
        branch_nz = 1'b0;
        jump      = 1'b0;
        rd        = id_instr[RS2_LSB +: 5];
        // 16-bit offset, sign extended
        imm = {{(32 - IMM_W){id_instr[IMM_LSB + IMM_W - 1]}}, id_instr[IMM_LSB +: IMM_W]};
        case (opcode)
            op_rtype: begin
                use_imm   = 1'b0;
                reg_write = 1'b1;
                rd        = id_instr[RD_LSB +: 5];
                case (func)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    default: reg_write = 1'b0;
                endcase
            end
            op_addi: reg_write = 1'b1;
            op_lw: begin
                reg_write = 1'b1;
                load      = 1'b1;
            end
            op_sw:   store = 1'b1;
            op_beqz: branch = 1'b1;
            op_bnez: begin
                branch    = 1'b1;
                branch_nz = 1'b1;
            end
            op_j: begin
                jump = 1'b1;
                imm  = {{(32 - OFF_W){id_instr[OFF_LSB + OFF_W - 1]}}, id_instr[OFF_LSB +: OFF_W]};
            end
            default: ;
        endcase
        // writes to r0 are dropped here, so nops carry no write
        if (rd == '0) begin
            reg_write = 1'b0;
        end
    end

    //////////////////////////////
    // ID/EX register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_reg_write <= 1'b0;
            ex_load      <= 1'b0;
            ex_store     <= 1'b0;
            ex_branch    <= 1'b0;
            ex_branch_nz <= 1'b0;
            ex_jump      <= 1'b0;
        end else if (!mem_hold) begin
            // bubble on load-use or flush
            ex_reg_write <= reg_write & ~(load_stall | redirect);
            ex_load      <= load & ~(load_stall | redirect);
            ex_store     <= store & ~(load_stall | redirect);
            ex_branch    <= branch & ~(load_stall | redirect);
            ex_branch_nz <= branch_nz;
            ex_jump      <= jump & ~(load_stall | redirect);
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_hold) begin
            ex_next_pc <= id_next_pc;
            ex_a       <= rs1_val;
            ex_b       <= rs2_val;
            ex_imm     <= imm;
            ex_rs1     <= rs1;
            ex_rs2     <= rs2;
            ex_rd      <= rd;
            ex_alu_op  <= alu_op;
            ex_use_imm <= use_imm;
        end
    end

endmodule

// ==== src/dlx_hazard.sv ====
`timescale 1ns/1ns

module dlx_hazard (
    input  dlx_pkg::reg_idx_t ex_rs1,
    input  dlx_pkg::reg_idx_t ex_rs2,
    input  logic              ex_load,
    input  dlx_pkg::reg_idx_t ex_rd,
    input  dlx_pkg::reg_idx_t id_rs1,
    input  dlx_pkg::reg_idx_t id_rs2,
    input  dlx_pkg::reg_idx_t mem_rd,
    input  logic              mem_reg_write,
    input  logic              mem_load,
    input  dlx_pkg::reg_idx_t wb_rd,
    input  logic              wb_reg_write,
    output dlx_pkg::fwd_sel_t fwd_a,
    output dlx_pkg::fwd_sel_t fwd_b,
    output logic              load_stall
);
    import dlx_pkg::*;

    // youngest producer wins
    // a load in memory has no data yet and the stall keeps it out of reach
    function automatic fwd_sel_t fwd_pick(reg_idx_t rs);
        if (rs == '0) begin
            return fwd_reg;
        end
        if (mem_reg_write && !mem_load && mem_rd == rs) begin
            return fwd_mem;
        end
        if (wb_reg_write && wb_rd == rs) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    always_comb begin
        fwd_a = fwd_pick(ex_rs1);
        fwd_b = fwd_pick(ex_rs2);
    end

    // load in execute feeding decode, one bubble
    // i-types also compare their rs2 field and may stall once more
    assign load_stall = ex_load && ex_rd != '0 &&
                        (ex_rd == id_rs1 || ex_rd == id_rs2);

endmodule

// ==== src/dlx_execute.sv ====
`timescale 1ns/1ns

module dlx_execute (
    input  logic              clk,
    input  logic              rst,
    input  dlx_pkg::word_t    ex_next_pc,
    input  dlx_pkg::word_t    ex_a,
    input  dlx_pkg::word_t    ex_b,
    input  dlx_pkg::word_t    ex_imm,
    input  dlx_pkg::reg_idx_t ex_rd,
    input  dlx_pkg::alu_op_t  ex_alu_op,
    input  logic              ex_use_imm,
    input  logic              ex_reg_write,
    input  logic              ex_load,
    input  logic              ex_store,
    input  logic              ex_branch,
    input  logic              ex_branch_nz,
    input  logic              ex_jump,
    input  dlx_pkg::fwd_sel_t fwd_a,
    input  dlx_pkg::fwd_sel_t fwd_b,
    input  dlx_pkg::word_t    wb_val,
    input  logic              mem_hold,
    output dlx_pkg::word_t    mem_alu,
    output dlx_pkg::word_t    mem_store_data,
    output dlx_pkg::reg_idx_t mem_rd,
    output logic              mem_reg_write,
    output logic              mem_load,
    output logic              mem_store,
    output logic              redirect,
    output dlx_pkg::word_t    redirect_pc
);
    import dlx_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_res;
    logic  taken;

    // forwarding muxes, op_b doubles as store data
    assign op_a = (fwd_a == fwd_mem) ? mem_alu : (fwd_a == fwd_wb) ? wb_val : ex_a;
    assign op_b = (fwd_b == fwd_mem) ? mem_alu : (fwd_b == fwd_wb) ? wb_val : ex_b;
    assign alu_b = ex_use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_alu_op)
            alu_sub: alu_res = op_a - alu_b;
            alu_and: alu_res = op_a & alu_b;
            alu_or:  alu_res = op_a | alu_b;
            alu_xor: alu_res = op_a ^ alu_b;
            alu_slt: alu_res = word_t'($signed(op_a) < $signed(alu_b));
            default: alu_res = op_a + alu_b;
        endcase
    end

    // beqz / bnez test rs1 against zero
    assign taken = ex_jump | (ex_branch & ((op_a == '0) ^ ex_branch_nz));

    //////////////////////////////
    // EX/MEM register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_reg_write <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            redirect      <= 1'b0;
        end else if (!mem_hold) begin
            // the instruction behind a taken branch is dropped
            mem_reg_write <= ex_reg_write & ~redirect;
            mem_load      <= ex_load & ~redirect;
            mem_store     <= ex_store & ~redirect;
            redirect      <= taken & ~redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_hold) begin
            mem_alu        <= alu_res;
            mem_store_data <= op_b;
            mem_rd         <= ex_rd;
            // target relative to the next pc
            redirect_pc    <= ex_next_pc + ex_imm;
        end
    end

endmodule

// ==== src/dlx_mem_wb.sv ====
`timescale 1ns/1ns

module dlx_mem_wb (
    input  logic              clk,
    input  logic              rst,
    input  dlx_pkg::word_t    mem_alu,
    input  dlx_pkg::word_t    mem_store_data,
    input  dlx_pkg::reg_idx_t mem_rd,
    input  logic              mem_reg_write,
    input  logic              mem_load,
    input  logic              mem_store,
    output logic              data_req,
    output dlx_pkg::word_t    data_addr,
    output logic              data_we,
    output dlx_pkg::word_t    data_wdata,
    input  logic              data_done,
    input  dlx_pkg::word_t    data_rdata,
    input  logic              mem_hold,
    output dlx_pkg::reg_idx_t wb_rd,
    output logic              wb_reg_write,
    output dlx_pkg::word_t    wb_val
);
    import dlx_pkg::*;

    logic  wb_load;
    word_t wb_alu;
    word_t wb_ldata;

    // data access straight from EX/MEM
    assign data_req   = mem_load | mem_store;
    assign data_addr  = mem_alu;
    assign data_we    = mem_store;
    assign data_wdata = mem_store_data;

    //////////////////////////////
    // MEM/WB register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_reg_write <= 1'b0;
            wb_load      <= 1'b0;
        end else if (!mem_hold) begin
            wb_reg_write <= mem_reg_write;
            wb_load      <= mem_load;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_hold) begin
            wb_rd  <= mem_rd;
            wb_alu <= mem_alu;
        end
        // load word caught at the handshake
        if (data_done && mem_load) begin
            wb_ldata <= data_rdata;
        end
    end

    // write-back select
    assign wb_val = wb_load ? wb_ldata : wb_alu;

endmodule

// ==== src/dlx_mem_arbiter.sv ====
`timescale 1ns/1ns

module dlx_mem_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           fetch_req,
    input  dlx_pkg::word_t fetch_addr,
    output logic           fetch_done,
    output dlx_pkg::word_t fetch_rdata,
    input  logic           data_req,
    input  dlx_pkg::word_t data_addr,
    input  logic           data_we,
    input  dlx_pkg::word_t data_wdata,
    output logic           data_done,
    output dlx_pkg::word_t data_rdata,
    output logic           mem_hold,
    output logic           mem_valid,
    output dlx_pkg::word_t mem_addr,
    output logic           mem_we,
    output dlx_pkg::word_t mem_wdata,
    input  logic           mem_ready,
    input  dlx_pkg::word_t mem_rdata
);
    import dlx_pkg::*;

    // owner of a handshake left waiting on ready
    typedef enum logic [1:0] {
        own_none,
        own_fetch,
        own_data
    } owner_t;

    owner_t owner;
    logic   fetch_sel;

    // a waiting transfer keeps the bus, otherwise data first
    always_comb begin
        case (owner)
            own_fetch: fetch_sel = 1'b1;
            own_data:  fetch_sel = 1'b0;
            default:   fetch_sel = !data_req;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= own_none;
        end else if (mem_valid && !mem_ready) begin
            owner <= fetch_sel ? own_fetch : own_data;
        end else begin
            owner <= own_none;
        end
    end

    // bus steering, wdata zero on fetches so it stays put
    assign mem_valid = fetch_sel ? fetch_req : data_req;
    assign mem_addr  = fetch_sel ? fetch_addr : data_addr;
    assign mem_we    = !fetch_sel && data_we;
    assign mem_wdata = fetch_sel ? '0 : data_wdata;

    assign fetch_done  = fetch_sel && fetch_req && mem_ready;
    assign data_done   = !fetch_sel && data_req && mem_ready;
    assign fetch_rdata = mem_rdata;
    assign data_rdata  = mem_rdata;

    // pending data access freezes the pipe
    assign mem_hold = data_req && !data_done;

endmodule

// ==== src/dlx_core_top.sv ====
`timescale 1ns/1ns

module dlx_core_top #(
    parameter dlx_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst,
    output logic           mem_valid,
    output logic           mem_we,
    output dlx_pkg::word_t mem_addr,
    output dlx_pkg::word_t mem_wdata,
    input  logic           mem_ready,
    input  dlx_pkg::word_t mem_rdata
);
    import dlx_pkg::*;

    //////////////////////////////
    // fetch and decode
    //////////////////////////////

    logic     fetch_req;
    logic     fetch_done;
    word_t    fetch_addr;
    word_t    fetch_rdata;
    word_t    id_instr;
    word_t    id_next_pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_val;
    word_t    rs2_val;

    // ID/EX
    word_t    ex_next_pc;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_imm;
    reg_idx_t ex_rs1;
    reg_idx_t ex_rs2;
    reg_idx_t ex_rd;
    alu_op_t  ex_alu_op;
    logic     ex_use_imm;
    logic     ex_reg_write;
    logic     ex_load;
    logic     ex_store;
    logic     ex_branch;
    logic     ex_branch_nz;
    logic     ex_jump;

    // hazards, flush
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     load_stall;
    logic     redirect;
    word_t    redirect_pc;
    logic     mem_hold;

    //////////////////////////////
    // memory and write-back
    //////////////////////////////

    word_t    mem_alu;
    word_t    mem_store_data;
    reg_idx_t mem_rd;
    logic     mem_reg_write;
    logic     mem_load;
    logic     mem_store;
    logic     data_req;
    logic     data_we;
    logic     data_done;
    word_t    data_addr;
    word_t    data_wdata;
    word_t    data_rdata;
    reg_idx_t wb_rd;
    logic     wb_reg_write;
    word_t    wb_val;

    dlx_fetch #(.RESET_PC(RESET_PC)) u_fetch (.*);

    dlx_decode u_decode (.*);

    dlx_regfile u_regfile (
        .wb_we (wb_reg_write),
        .*
    );

    // decode indices feed the load-use check
    dlx_hazard u_hazard (
        .id_rs1 (rs1),
        .id_rs2 (rs2),
        .*
    );

    dlx_execute u_execute (.*);

    dlx_mem_wb u_mem_wb (.*);

    dlx_mem_arbiter u_mem_arbiter (.*);

endmodule

// ==== verif/dlx_clk_gen.sv ====
`timescale 1ns/1ns

module dlx_clk_gen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released 1 ns after the last reset edge, like other inputs
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== verif/dlx_pipe_asserts.sv ====
`timescale 1ns/1ns

module dlx_pipe_asserts (
    input logic           clk,
    input logic           rst,
    input logic           mem_valid,
    input logic           mem_we,
    input dlx_pkg::word_t mem_addr,
    input dlx_pkg::word_t mem_wdata,
    input logic           mem_ready
);

    int   err_count = 0;
    logic seen_xfer;

    // first handshake after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_xfer <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            seen_xfer <= 1'b1;
        end
    end

    //////////////////////////////
    // bus protocol
    //////////////////////////////

    // idle through reset and one cycle past it
    idle_after_reset: assert property (@(posedge clk) rst |=> !mem_valid)
        else begin
            err_count++;
            $error("mem_valid high during reset or in the first cycle after it");
        end

    first_fetch_at_zero: assert property (@(posedge clk)
        !rst && mem_valid && mem_ready && !seen_xfer |-> !mem_we && mem_addr == '0)
        else begin
            err_count++;
            $error("first bus transfer is not a read of address 0");
        end

    // request stays up until ready
    valid_held: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid)
        else begin
            err_count++;
            $error("mem_valid dropped before the transfer completed");
        end

    bus_held: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=>
            $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
        else begin
            err_count++;
            $error("mem_addr, mem_we or mem_wdata changed while waiting for mem_ready");
        end

    //////////////////////////////
    // stored results
    //////////////////////////////

    // both stores behind the taken branch are squashed
    no_squashed_store: assert property (@(posedge clk) disable iff (rst)
        mem_valid && mem_ready && mem_we |-> mem_addr != 32'd268)
        else begin
            err_count++;
            $error("write to address 268 from a squashed store");
        end

endmodule

// ==== verif/dlx_tb.sv ====
`timescale 1ns/1ns

module dlx_tb;
    import dlx_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int N_STORES     = 5;
    localparam int DRAIN_CYCLES = 20;
    // 19 instructions, a few bus transfers each at 3/4 ready, wide margin
    localparam int WATCHDOG_CYCLES = 2000;
    localparam logic [31:0] SEED   = 32'hf99b5b3a;

    // stores in program order
    localparam word_t STORE_ADDR [N_STORES] = '{32'd256, 32'd260, 32'd264, 32'd272, 32'd276};
    localparam word_t STORE_DATA [N_STORES] = '{32'd12, 32'd7, 32'd13, 32'd7, 32'd3};

    logic  clk;
    logic  rst;
    logic  mem_valid;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_ready;
    word_t mem_rdata;

    word_t mem [MEM_WORDS];
    int    store_count  = 0;
    int    check_errors = 0;

    dlx_clk_gen #(.PERIOD(8), .RST_CYCLES(3)) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    dlx_core_top #(.RESET_PC(32'd0)) UUT (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    bind dlx_core_top dlx_pipe_asserts u_asserts (
        .clk       (clk),
        .rst       (rst),
        .mem_valid (mem_valid),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready)
    );

    //////////////////////////////
    // instruction encoding
    //////////////////////////////

    function automatic word_t itype(opcode_t op, int rs1, int rd, int imm);
        return {op, 5'(rs1), 5'(rd), 16'(imm)};
    endfunction

    function automatic word_t rtype(func_t fn, int rs1, int rs2, int rd);
        return {op_rtype, 5'(rs1), 5'(rs2), 5'(rd), 5'd0, fn};
    endfunction

    // offset relative to the next pc
    function automatic word_t jump_to(int off);
        return {op_j, 26'(off)};
    endfunction

    // background is addi r0,r0,addr so stray fetches do nothing
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {op_addi, 5'd0, 5'd0, 16'(i * 4)};
        end
        mem[0]  = itype(op_addi, 0, 1, 5);
        mem[1]  = itype(op_addi, 0, 2, 7);
        mem[2]  = rtype(fn_add, 1, 2, 3);
        mem[3]  = rtype(fn_sub, 3, 1, 4);
        mem[4]  = itype(op_sw, 0, 3, 256);
        mem[5]  = itype(op_sw, 0, 4, 260);
        mem[6]  = itype(op_lw, 0, 8, 256);
        mem[7]  = itype(op_addi, 8, 9, 1);
        mem[8]  = itype(op_sw, 0, 9, 264);
        mem[9]  = itype(op_beqz, 0, 0, 8);
        mem[10] = itype(op_sw, 0, 1, 268);
        mem[11] = itype(op_sw, 0, 1, 268);
        mem[12] = rtype(fn_or, 1, 2, 10);
        mem[13] = itype(op_sw, 0, 10, 272);
        mem[14] = rtype(fn_xor, 1, 2, 11);
        mem[15] = rtype(fn_slt, 1, 2, 12);
        mem[16] = rtype(fn_add, 11, 12, 13);
        mem[17] = itype(op_sw, 0, 13, 276);
        mem[18] = jump_to(-4);
    end

    //////////////////////////////
    // memory model
    //////////////////////////////

    // read data valid in the handshake cycle
    assign mem_rdata = mem[mem_addr[9:2]];

    // random back-pressure, a quarter of the cycles stalled
    initial begin
        void'($urandom(SEED));
        mem_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            mem_ready = ($urandom_range(3) != 0);
        end
    end

    // each write compared with the next expected store
    task automatic check_store(input word_t addr, input word_t data);
        assert (store_count < N_STORES) else begin
            $display("unexpected write of %0d to address %0d at %0t after the last store",
                     data, addr, $time);
            check_errors++;
        end
        if (store_count < N_STORES) begin
            assert (addr == STORE_ADDR[store_count]) else begin
                $display("[ERROR] %0t mem_addr expected %0d actual %0d",
                         $time, STORE_ADDR[store_count], addr);
                check_errors++;
            end
            assert (data == STORE_DATA[store_count]) else begin
                $display("[ERROR] %0t mem_wdata expected %0d actual %0d",
                         $time, STORE_DATA[store_count], data);
                check_errors++;
            end
            store_count++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst && mem_valid && mem_ready && mem_we) begin
            mem[mem_addr[9:2]] <= mem_wdata;
            check_store(mem_addr, mem_wdata);
        end
    end

    //////////////////////////////
    // run control
    //////////////////////////////

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, only %0d of %0d stores seen within %0d cycles",
                 store_count, N_STORES, WATCHDOG_CYCLES);
        $display("errors: %0d testbench, %0d assertions",
                 check_errors, UUT.u_asserts.err_count);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        wait (store_count == N_STORES);
        // jump loop keeps running, any stray write is caught
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("errors: %0d testbench, %0d assertions",
                 check_errors, UUT.u_asserts.err_count);
        if (check_errors == 0 && UUT.u_asserts.err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== dlx_pipe.f ====
src/dlx_pkg.sv
src/dlx_fetch.sv
src/dlx_regfile.sv
src/dlx_decode.sv
src/dlx_hazard.sv
src/dlx_execute.sv
src/dlx_mem_wb.sv
src/dlx_mem_arbiter.sv
src/dlx_core_top.sv
verif/dlx_clk_gen.sv
verif/dlx_pipe_asserts.sv
verif/dlx_tb.sv

// ==== Bender.yml ====
package:
  name: dlx_pipe

sources:
  - src/dlx_pkg.sv
  - src/dlx_fetch.sv
  - src/dlx_regfile.sv
  - src/dlx_decode.sv
  - src/dlx_hazard.sv
  - src/dlx_execute.sv
  - src/dlx_mem_wb.sv
  - src/dlx_mem_arbiter.sv
  - src/dlx_core_top.sv
  - target: test
    files:
      - verif/dlx_clk_gen.sv
      - verif/dlx_pipe_asserts.sv
      - verif/dlx_tb.sv
